//--- hw/execPkg.sv
// Execute stage shared widths, opcodes, function codes, fault causes and instruction formats
package execPkg;

	localparam int DataWidth = 64;
	localparam int IpWidth = 32;
	localparam int StreamWidth = 6;
	localparam int RobIdxWidth = 6;
	localparam int CauseWidth = 16;
	localparam int ImmWidth = 12;

	// ====================
	// Fault causes
	// ====================
	localparam logic [CauseWidth-1:0] FltNone = 16'h0000;
	localparam logic [CauseWidth-1:0] FltChk = 16'h0023;

	// ====================
	// Major opcodes
	// ====================
	typedef enum logic [7:0] {
		R2     = 8'h02,
		ADDI   = 8'h04,
		SUBFI  = 8'h05,
		ANDI   = 8'h08,
		ORI    = 8'h09,
		XORI   = 8'h0A,
		SLTI   = 8'h10,
		SLTUI  = 8'h11,
		SGTI   = 8'h12,
		SGTUI  = 8'h13,
		BYTNDX = 8'h1C,
		CHKI   = 8'h1D,
		BEQ    = 8'h20,
		BNE    = 8'h21,
		BLT    = 8'h22,
		BGE    = 8'h23,
		BLTU   = 8'h24,
		BGEU   = 8'h25,
		JALR   = 8'h28
	} opcodeT;

	// Function field of the R2 register form
	typedef enum logic [5:0] {
		ADD  = 6'h04,
		SUB  = 6'h05,
		AND  = 6'h08,
		OR   = 6'h09,
		XOR  = 6'h0A,
		SLL  = 6'h10,
		SLLI = 6'h11,
		CMP  = 6'h18,
		SEQ  = 6'h20,
		SNE  = 6'h21,
		SLT  = 6'h22,
		SGE  = 6'h23,
		SLTU = 6'h24,
		SGEU = 6'h25
	} funcT;

	// ====================
	// Instruction word
	// ====================
	typedef struct packed {
		funcT       func;
		logic [5:0] rb;
		logic [5:0] ra;
		logic [5:0] rt;
		opcodeT     opcode;
	} regFormT;

	typedef struct packed {
		logic [ImmWidth-1:0] imm;
		logic [5:0]          ra;
		logic [5:0]          rt;
		opcodeT              opcode;
	} immFormT;

	// Both forms share opcode, rt and ra; the top twelve bits are rb/func or imm
	typedef union packed {
		regFormT r;
		immFormT i;
	} instrWordT;

	function automatic logic [DataWidth-1:0] immExt(input instrWordT w);
		return {{(DataWidth-ImmWidth){w.i.imm[ImmWidth-1]}}, w.i.imm};
	endfunction

endpackage

//--- hw/intAlu.sv
// Integer ALU for register and immediate arithmetic, logic, shift, compare and byte index
module intAlu import execPkg::*; (
	input  instrWordT            instr,
	input  logic [DataWidth-1:0] opA,
	input  logic [DataWidth-1:0] opB,
	output logic [DataWidth-1:0] aluResult,
	output logic                 aluHit
);

	logic [DataWidth-1:0] imm;
	logic [7:0] byteKey;
	logic [DataWidth-1:0] byteIdx;
	logic [DataWidth-1:0] cmpResult;

	assign imm = immExt(instr);

	// Func zero searches for the low byte of opB, otherwise the immediate is the key
	assign byteKey = (instr.r.func != 6'd0) ? instr.i.imm[7:0] : opB[7:0];

	// Scan from the top lane down so the lowest matching lane wins
	always_comb begin
		byteIdx = '1;
		for (int lane = 7; lane >= 0; lane--) begin
			if (opA[lane*8 +: 8] == byteKey)
				byteIdx = DataWidth'(lane);
		end
	end

	always_comb begin
		if ($signed(opA) < $signed(opB))
			cmpResult = '1;
		else if (opA == opB)
			cmpResult = '0;
		else
			cmpResult = DataWidth'(1);
	end

	// ====================
	// Result select
	// ====================
	always_comb begin
		aluResult = '0;
		aluHit = 1'b1;
		case (instr.r.opcode)
			R2: begin
				case (instr.r.func)
					ADD:  aluResult = opA + opB;
					SUB:  aluResult = opA - opB;
					AND:  aluResult = opA & opB;
					OR:   aluResult = opA | opB;
					XOR:  aluResult = opA ^ opB;
					SLL:  aluResult = opA << opB[5:0];
					SLLI: aluResult = opA << instr.r.rb;
					CMP:  aluResult = cmpResult;
					SEQ:  aluResult = DataWidth'(opA == opB);
					SNE:  aluResult = DataWidth'(opA != opB);
					SLT:  aluResult = DataWidth'($signed(opA) < $signed(opB));
					SGE:  aluResult = DataWidth'($signed(opA) >= $signed(opB));
					SLTU: aluResult = DataWidth'(opA < opB);
					SGEU: aluResult = DataWidth'(opA >= opB);
					default: aluHit = 1'b0;
				endcase
			end
			ADDI:   aluResult = opA + imm;
			SUBFI:  aluResult = imm - opA;
			ANDI:   aluResult = opA & imm;
			ORI:    aluResult = opA | imm;
			XORI:   aluResult = opA ^ imm;
			SLTI:   aluResult = DataWidth'($signed(opA) < $signed(imm));
			SGTI:   aluResult = DataWidth'($signed(opA) > $signed(imm));
			// Unsigned forms still compare against the sign-extended immediate
			SLTUI:  aluResult = DataWidth'(opA < imm);
			SGTUI:  aluResult = DataWidth'(opA > imm);
			BYTNDX: aluResult = byteIdx;
			default: aluHit = 1'b0;
		endcase
	end

endmodule

//--- hw/branchCheck.sv
// Branch and jump resolution with the immediate bounds-check fault test
module branchCheck import execPkg::*; (
	input  instrWordT            instr,
	input  logic [IpWidth-1:0]   ip,
	input  logic [DataWidth-1:0] opA,
	input  logic [DataWidth-1:0] opC,
	input  logic                 takeBranch,
	input  logic                 predictTaken,
	output logic                 brHit,
	output logic                 chkHit,
	output logic                 chkFault,
	output logic                 redirectNeeded,
	output logic [DataWidth-1:0] linkResult,
	output logic [IpWidth-1:0]   targetIp
);

	logic [DataWidth-1:0] imm;
	logic isBranch;
	logic isJalr;
	logic [IpWidth-1:0] seqIp;
	logic [DataWidth-1:0] jumpSum;
	logic [DataWidth-1:0] branchSum;
	logic [2:0] chkMode;
	logic loLt;
	logic hiLt;
	logic lowOk;
	logic highOk;

	assign imm = immExt(instr);

	always_comb begin
		case (instr.r.opcode)
			BEQ, BNE, BLT, BGE, BLTU, BGEU: isBranch = 1'b1;
			default: isBranch = 1'b0;
		endcase
	end

	assign isJalr = (instr.r.opcode == JALR);
	assign brHit = isBranch | isJalr;

	// ====================
	// Link and target
	// ====================
	assign seqIp = ip + IpWidth'(4);
	assign linkResult = {{(DataWidth-IpWidth){1'b0}}, seqIp};
	assign jumpSum = opA + imm;
	assign branchSum = opC + imm;

	always_comb begin
		if (isJalr)
			targetIp = {jumpSum[IpWidth-1:2], 2'b00};
		else if (takeBranch)
			targetIp = branchSum[IpWidth-1:0];
		else
			targetIp = seqIp;
	end

	// A jump always leaves the predicted path
	assign redirectNeeded = isJalr | (isBranch & (takeBranch != predictTaken));

	// ====================
	// Bounds check
	// ====================
	// Mode bit 2 picks signed compares, bit 0 and bit 1 make the lower and upper bound exclusive
	assign chkHit = (instr.r.opcode == CHKI);
	assign chkMode = instr.r.rt[2:0];

	always_comb begin
		if (chkMode[2]) begin
			loLt = $signed(opC) < $signed(opA);
			hiLt = $signed(opA) < $signed(imm);
		end
		else begin
			loLt = opC < opA;
			hiLt = opA < imm;
		end
	end

	assign lowOk = loLt | (~chkMode[0] & (opC == opA));
	assign highOk = hiLt | (~chkMode[1] & (opA == imm));
	assign chkFault = chkHit & ~(lowOk & highOk);

endmodule

//--- hw/execCommit.sv
// Commit unit that registers the retire record, reorder index, stream tag and redirect
module execCommit import execPkg::*; #(
	parameter int                 RobEntries = 64,
	parameter logic [IpWidth-1:0] ResetIp = 32'hFFFC0000
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   issueValid,
	input  logic [StreamWidth-1:0] streamTag,
	input  logic [CauseWidth-1:0]  causeIn,
	input  logic                   takeBranch,
	input  logic [DataWidth-1:0]   aluResult,
	input  logic                   aluHit,
	input  logic                   brHit,
	input  logic                   chkHit,
	input  logic                   chkFault,
	input  logic                   redirectNeeded,
	input  logic [DataWidth-1:0]   linkResult,
	input  logic [IpWidth-1:0]     targetIp,
	output logic                   retireValid,
	output logic                   retireSquashed,
	output logic                   branchTaken,
	output logic                   redirectValid,
	output logic                   flush,
	output logic [RobIdxWidth-1:0] retireIdx,
	output logic [DataWidth-1:0]   retireResult,
	output logic [CauseWidth-1:0]  retireCause,
	output logic [IpWidth-1:0]     redirectIp,
	output logic [StreamWidth-1:0] exStream
);

	logic [RobIdxWidth-1:0] idxReg;
	logic [RobIdxWidth-1:0] nextIdx;
	logic streamMatch;
	logic faulted;
	logic retires;
	logic doRedirect;
	logic takenNext;
	logic [DataWidth-1:0] resultNext;
	logic [CauseWidth-1:0] causeNext;

	assign nextIdx = (idxReg == RobIdxWidth'(RobEntries - 1)) ? '0 : idxReg + 1'b1;

	assign streamMatch = (streamTag == exStream);
	assign faulted = (causeIn != FltNone);

	// Anything on a stale stream retires, live ones only when some unit claims the opcode
	assign retires = issueValid & (~streamMatch | faulted | chkHit | brHit | aluHit);
	assign doRedirect = issueValid & streamMatch & ~faulted & ~chkHit & brHit & redirectNeeded;

	// ====================
	// Retire priority
	// ====================
	always_comb begin
		resultNext = '0;
		causeNext = FltNone;
		takenNext = 1'b0;
		if (!streamMatch) begin
			resultNext = '0;
		end
		else if (faulted) begin
			causeNext = causeIn;
		end
		else if (chkHit) begin
			if (chkFault)
				causeNext = FltChk;
		end
		else if (brHit) begin
			resultNext = linkResult;
			takenNext = takeBranch;
		end
		else begin
			resultNext = aluResult;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			idxReg <= '0;
			retireIdx <= '0;
			exStream <= '0;
			retireValid <= 1'b0;
			retireSquashed <= 1'b0;
			branchTaken <= 1'b0;
			redirectValid <= 1'b0;
			// Front end stays flushed until the first cycle out of reset
			flush <= 1'b1;
			redirectIp <= ResetIp;
		end
		else begin
			retireValid <= retires;
			redirectValid <= doRedirect;
			flush <= doRedirect;
			if (retires) begin
				retireIdx <= idxReg;
				idxReg <= nextIdx;
				retireSquashed <= ~streamMatch;
				branchTaken <= takenNext;
			end
			if (doRedirect) begin
				redirectIp <= targetIp;
				exStream <= exStream + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (retires) begin
			retireResult <= resultNext;
			retireCause <= causeNext;
		end
	end

endmodule

//--- hw/execStage.sv
// Scalar execute stage joining the ALU, the branch and check unit and the commit unit
module execStage import execPkg::*; #(
	parameter int                 RobEntries = 64,
	parameter logic [IpWidth-1:0] ResetIp = 32'hFFFC0000
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   issueValid,
	input  instrWordT              instr,
	input  logic [IpWidth-1:0]     ip,
	input  logic [DataWidth-1:0]   opA,
	input  logic [DataWidth-1:0]   opB,
	input  logic [DataWidth-1:0]   opC,
	input  logic [StreamWidth-1:0] streamTag,
	input  logic [CauseWidth-1:0]  causeIn,
	input  logic                   takeBranch,
	input  logic                   predictTaken,
	output logic                   retireValid,
	output logic                   retireSquashed,
	output logic                   branchTaken,
	output logic                   redirectValid,
	output logic                   flush,
	output logic [RobIdxWidth-1:0] retireIdx,
	output logic [DataWidth-1:0]   retireResult,
	output logic [CauseWidth-1:0]  retireCause,
	output logic [IpWidth-1:0]     redirectIp,
	output logic [StreamWidth-1:0] exStream
);

	logic [DataWidth-1:0] aluResult;
	logic aluHit;
	logic brHit;
	logic chkHit;
	logic chkFault;
	logic redirectNeeded;
	logic [DataWidth-1:0] linkResult;
	logic [IpWidth-1:0] targetIp;

	// ====================
	// Parallel units
	// ====================
	intAlu alu0 (
		.instr     (instr),
		.opA       (opA),
		.opB       (opB),
		.aluResult (aluResult),
		.aluHit    (aluHit)
	);

	branchCheck br0 (
		.instr          (instr),
		.ip             (ip),
		.opA            (opA),
		.opC            (opC),
		.takeBranch     (takeBranch),
		.predictTaken   (predictTaken),
		.brHit          (brHit),
		.chkHit         (chkHit),
		.chkFault       (chkFault),
		.redirectNeeded (redirectNeeded),
		.linkResult     (linkResult),
		.targetIp       (targetIp)
	);

	execCommit #(
		.RobEntries (RobEntries),
		.ResetIp    (ResetIp)
	) commit0 (
		.clk            (clk),
		.rst            (rst),
		.issueValid     (issueValid),
		.streamTag      (streamTag),
		.causeIn        (causeIn),
		.takeBranch     (takeBranch),
		.aluResult      (aluResult),
		.aluHit         (aluHit),
		.brHit          (brHit),
		.chkHit         (chkHit),
		.chkFault       (chkFault),
		.redirectNeeded (redirectNeeded),
		.linkResult     (linkResult),
		.targetIp       (targetIp),
		.retireValid    (retireValid),
		.retireSquashed (retireSquashed),
		.branchTaken    (branchTaken),
		.redirectValid  (redirectValid),
		.flush          (flush),
		.retireIdx      (retireIdx),
		.retireResult   (retireResult),
		.retireCause    (retireCause),
		.redirectIp     (redirectIp),
		.exStream       (exStream)
	);

endmodule

//--- tb/execTests.svh
// Directed tests for the execute stage, included inside the testbench module
`ifndef EXEC_TESTS_SVH
`define EXEC_TESTS_SVH

function automatic instrWordT regWord(input funcT f, input logic [5:0] rb);
	instrWordT w;
	w.r.opcode = R2;
	w.r.rt = 6'd1;
	w.r.ra = 6'd2;
	w.r.rb = rb;
	w.r.func = f;
	return w;
endfunction

function automatic instrWordT immWord(input opcodeT op, input logic [5:0] rt,
	input logic [11:0] imm);
	instrWordT w;
	w.i.opcode = op;
	w.i.rt = rt;
	w.i.ra = 6'd2;
	w.i.imm = imm;
	return w;
endfunction

function automatic logic [63:0] expectR2(input funcT f, input logic [63:0] a,
	input logic [63:0] b, input logic [5:0] rb);
	case (f)
		ADD:  return a + b;
		SUB:  return a - b;
		AND:  return a & b;
		OR:   return a | b;
		XOR:  return a ^ b;
		SLL:  return a << b[5:0];
		SLLI: return a << rb;
		CMP:  return ($signed(a) < $signed(b)) ? '1 : ((a == b) ? 64'd0 : 64'd1);
		SEQ:  return 64'(a == b);
		SNE:  return 64'(a != b);
		SLT:  return 64'($signed(a) < $signed(b));
		SGE:  return 64'($signed(a) >= $signed(b));
		SLTU: return 64'(a < b);
		SGEU: return 64'(a >= b);
		default: return 64'd0;
	endcase
endfunction

function automatic logic [63:0] expectImm(input opcodeT op, input logic [63:0] a,
	input logic [11:0] imm);
	logic [63:0] sx;
	sx = {{52{imm[11]}}, imm};
	case (op)
		ADDI:  return a + sx;
		SUBFI: return sx - a;
		ANDI:  return a & sx;
		ORI:   return a | sx;
		XORI:  return a ^ sx;
		SLTI:  return 64'($signed(a) < $signed(sx));
		SLTUI: return 64'(a < sx);
		SGTI:  return 64'($signed(a) > $signed(sx));
		SGTUI: return 64'(a > sx);
		default: return 64'd0;
	endcase
endfunction

function automatic logic [63:0] byteModel(input logic [63:0] a, input logic [7:0] key);
	logic [63:0] idx;
	logic found;
	idx = '1;
	found = 1'b0;
	for (int lane = 0; lane < 8; lane++) begin
		if (!found && a[lane*8 +: 8] == key) begin
			idx = 64'(lane);
			found = 1'b1;
		end
	end
	return idx;
endfunction

task automatic testReset();
	@(negedge clk);
	checkEq("reset retireValid", 64'd0, 64'(retireValid));
	checkEq("reset redirectValid", 64'd0, 64'(redirectValid));
	checkEq("reset exStream", 64'd0, 64'(exStream));
	checkEq("reset redirectIp", 64'(ResetIp), 64'(redirectIp));
	checkEq("reset flush held", 64'd1, 64'(flush));
	@(negedge clk);
	checkEq("reset flush released", 64'd0, 64'(flush));
endtask

task automatic testAluOps();
	funcT fList[14] = '{ADD, SUB, AND, OR, XOR, SLL, SLLI, CMP, SEQ, SNE, SLT, SGE, SLTU, SGEU};
	opcodeT iList[9] = '{ADDI, SUBFI, ANDI, ORI, XORI, SLTI, SLTUI, SGTI, SGTUI};
	logic [63:0] a;
	logic [63:0] b;
	logic [5:0] sh;
	logic [11:0] imm;
	string name;
	// Second pass of each op uses equal operands to reach the equality cases
	for (int k = 0; k < 14; k++) begin
		for (int rep = 0; rep < 2; rep++) begin
			a = randWord(64);
			b = (rep == 0) ? randWord(64) : a;
			sh = 6'(randWord(6));
			name = $sformatf("R2 %s pass %0d", fList[k].name(), rep);
			execOne(name, regWord(fList[k], sh), 32'h1000, a, b, 64'd0);
			checkRetire(name, expectR2(fList[k], a, b, sh), FltNone, 1'b0, 1'b0);
		end
	end
	for (int k = 0; k < 9; k++) begin
		for (int rep = 0; rep < 2; rep++) begin
			imm = 12'(randWord(12));
			a = (rep == 0) ? randWord(64) : {{52{imm[11]}}, imm};
			name = $sformatf("%s pass %0d", iList[k].name(), rep);
			execOne(name, immWord(iList[k], 6'd3, imm), 32'h1000, a, 64'd0, 64'd0);
			checkRetire(name, expectImm(iList[k], a, imm), FltNone, 1'b0, 1'b0);
		end
	end
endtask

// Back-to-back issue long enough that the reorder index must wrap
task automatic testIndexWrap();
	int count;
	count = RobEntries + 3;
	@(posedge clk);
	issueValid <= 1'b1;
	instr <= regWord(ADD, 6'd0);
	opA <= 64'd5;
	opB <= 64'd7;
	causeIn <= FltNone;
	streamTag <= 6'(curStream);
	for (int n = 0; n < count; n++) begin
		@(posedge clk);
		if (n == count - 1)
			issueValid <= 1'b0;
		@(negedge clk);
		checkEq("back to back valid", 64'd1, 64'(retireValid));
		checkEq("back to back idx", 64'(expIdx), 64'(retireIdx));
		checkEq("back to back result", 64'd12, retireResult);
		expIdx = (expIdx == RobEntries - 1) ? 0 : expIdx + 1;
	end
endtask

task automatic runByteCase(input string name, input logic [63:0] a, input logic [63:0] b,
	input logic [11:0] imm);
	logic [7:0] key;
	// The func field overlaps imm[11:6] and picks the key source
	key = (imm[11:6] != 6'd0) ? imm[7:0] : b[7:0];
	execOne(name, immWord(BYTNDX, 6'd1, imm), 32'h3000, a, b, 64'd0);
	checkRetire(name, byteModel(a, key), FltNone, 1'b0, 1'b0);
endtask

task automatic testByteIndex();
	logic [63:0] a;
	runByteCase("byte key from opB", 64'h1716151413121110, 64'h15, 12'h02A);
	runByteCase("byte key from imm", 64'h1716151413121110, 64'h15, {4'h4, 8'h12});
	runByteCase("byte no match", 64'h1716151413121110, 64'hAA, 12'h000);
	a = randWord(64);
	a[15:8] = a[55:48];
	runByteCase("byte lowest lane", a, {56'd0, a[55:48]}, 12'h000);
endtask

task automatic testBoundsCheck();
	logic [63:0] lo;
	logic [63:0] aVal[5];
	logic expFault[5];
	string name;
	// Upper bound is the immediate 200 and the lower bound comes in on opC
	for (int mode = 0; mode < 8; mode++) begin
		lo = mode[2] ? 64'hFFFF_FFFF_FFFF_FF9C : 64'd10;
		aVal[0] = mode[2] ? 64'hFFFF_FFFF_FFFF_FFFB : 64'd100;
		aVal[1] = lo;
		aVal[2] = 64'd200;
		aVal[3] = 64'd201;
		aVal[4] = mode[2] ? lo - 64'd1 : 64'hFFFF_FFFF_FFFF_FFFB;
		expFault[0] = 1'b0;
		expFault[1] = mode[0];
		expFault[2] = mode[1];
		expFault[3] = 1'b1;
		expFault[4] = 1'b1;
		for (int c = 0; c < 5; c++) begin
			name = $sformatf("CHKI mode %0d case %0d", mode, c);
			execOne(name, immWord(CHKI, 6'(mode), 12'd200), 32'h2000, aVal[c], 64'd0, lo);
			checkRetire(name, 64'd0, expFault[c] ? FltChk : FltNone, 1'b0, 1'b0);
		end
	end
endtask

task automatic checkBranch(input string name, input logic [31:0] ipv, input logic taken,
	input logic redirect, input logic [31:0] target);
	if (redirect)
		curStream++;
	checkRetire(name, {32'd0, ipv + 32'd4}, FltNone, 1'b0, redirect);
	checkEq({name, " taken"}, 64'(taken), 64'(branchTaken));
	checkEq({name, " stream"}, 64'(6'(curStream)), 64'(exStream));
	if (redirect)
		checkEq({name, " target"}, 64'(target), 64'(redirectIp));
endtask

task automatic testBranches();
	logic [31:0] ipv;
	logic [63:0] a;
	logic [63:0] c;
	logic [11:0] imm;
	logic [63:0] sx;
	ipv = 32'(randWord(30) << 2);
	a = randWord(64);
	c = randWord(64);
	imm = 12'(randWord(12));
	sx = {{52{imm[11]}}, imm};
	execOne("BEQ predicted taken", immWord(BEQ, 6'd0, imm), ipv, a, 64'd0, c, 1'b1, 1'b1);
	checkBranch("BEQ predicted taken", ipv, 1'b1, 1'b0, 32'd0);
	execOne("BGE predicted not taken", immWord(BGE, 6'd0, imm), ipv, a, 64'd0, c);
	checkBranch("BGE predicted not taken", ipv, 1'b0, 1'b0, 32'd0);
	execOne("BNE mispredict taken", immWord(BNE, 6'd0, imm), ipv, a, 64'd0, c, 1'b1, 1'b0);
	checkBranch("BNE mispredict taken", ipv, 1'b1, 1'b1, 32'(c + sx));
	execOne("BLTU mispredict fall", immWord(BLTU, 6'd0, imm), ipv, a, 64'd0, c, 1'b0, 1'b1);
	checkBranch("BLTU mispredict fall", ipv, 1'b0, 1'b1, ipv + 32'd4);
	execOne("JALR", immWord(JALR, 6'd1, imm), ipv, a, 64'd0, c);
	checkBranch("JALR", ipv, 1'b0, 1'b1, 32'(a + sx) & ~32'h3);
	a = randWord(64);
	execOne("JALR predicted", immWord(JALR, 6'd1, imm), ipv, a, 64'd0, c, 1'b1, 1'b1);
	checkBranch("JALR predicted", ipv, 1'b1, 1'b1, 32'(a + sx) & ~32'h3);
endtask

task automatic testSquashFault();
	logic [63:0] a;
	a = randWord(64);
	execOne("stale ADD", regWord(ADD, 6'd0), 32'h4000, a, 64'd9, 64'd0,
		1'b0, 1'b0, FltNone, 1'b1);
	checkRetire("stale ADD", 64'd0, FltNone, 1'b1, 1'b0);
	execOne("stale BNE", immWord(BNE, 6'd0, 12'h010), 32'h4000, a, 64'd0, 64'd0,
		1'b1, 1'b0, FltNone, 1'b1);
	checkRetire("stale BNE", 64'd0, FltNone, 1'b1, 1'b0);
	checkEq("stale BNE stream", 64'(6'(curStream)), 64'(exStream));
	execOne("faulted ADD", regWord(ADD, 6'd0), 32'h4000, a, 64'd9, 64'd0,
		1'b0, 1'b0, 16'h0042);
	checkEq("faulted ADD cause", 64'h0042, 64'(retireCause));
	checkEq("faulted ADD squash", 64'd0, 64'(retireSquashed));
	checkEq("faulted ADD redirect", 64'd0, 64'(redirectValid));
	// A faulted jump must not steer the front end
	execOne("faulted JALR", immWord(JALR, 6'd1, 12'h020), 32'h4000, a, 64'd0, 64'd0,
		1'b0, 1'b0, 16'h0107);
	checkEq("faulted JALR cause", 64'h0107, 64'(retireCause));
	checkEq("faulted JALR redirect", 64'd0, 64'(redirectValid));
	checkEq("faulted JALR stream", 64'(6'(curStream)), 64'(exStream));
	execOne("live ADD", regWord(ADD, 6'd0), 32'h4000, a, 64'd9, 64'd0);
	checkRetire("live ADD", a + 64'd9, FltNone, 1'b0, 1'b0);
endtask

`endif

//--- tb/execStageTb.sv
// Testbench for the execute stage with clock, reset, LFSR operands and the closing report
module execStageTb import execPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RobEntries = 48;
	localparam logic [IpWidth-1:0] ResetIp = 32'hFFFC0100;
	localparam int RetireTimeout = 20;

	logic clk;
	logic rst;
	logic issueValid;
	instrWordT instr;
	logic [IpWidth-1:0] ip;
	logic [DataWidth-1:0] opA;
	logic [DataWidth-1:0] opB;
	logic [DataWidth-1:0] opC;
	logic [StreamWidth-1:0] streamTag;
	logic [CauseWidth-1:0] causeIn;
	logic takeBranch;
	logic predictTaken;
	logic retireValid;
	logic retireSquashed;
	logic branchTaken;
	logic redirectValid;
	logic flush;
	logic [RobIdxWidth-1:0] retireIdx;
	logic [DataWidth-1:0] retireResult;
	logic [CauseWidth-1:0] retireCause;
	logic [IpWidth-1:0] redirectIp;
	logic [StreamWidth-1:0] exStream;

	int errors = 0;
	int checks = 0;
	// Reorder index and stream tag that the DUT should hold next
	int expIdx = 0;
	int curStream = 0;
	logic [31:0] lfsrState = 32'h9820011d;

	execStage #(
		.RobEntries (RobEntries),
		.ResetIp    (ResetIp)
	) dut0 (
		.clk            (clk),
		.rst            (rst),
		.issueValid     (issueValid),
		.instr          (instr),
		.ip             (ip),
		.opA            (opA),
		.opB            (opB),
		.opC            (opC),
		.streamTag      (streamTag),
		.causeIn        (causeIn),
		.takeBranch     (takeBranch),
		.predictTaken   (predictTaken),
		.retireValid    (retireValid),
		.retireSquashed (retireSquashed),
		.branchTaken    (branchTaken),
		.redirectValid  (redirectValid),
		.flush          (flush),
		.retireIdx      (retireIdx),
		.retireResult   (retireResult),
		.retireCause    (retireCause),
		.redirectIp     (redirectIp),
		.exStream       (exStream)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ====================
	// Helpers
	// ====================
	// Taps 32, 22, 2, 1
	function automatic logic lfsrStep();
		logic fb;
		fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] randWord(input int nBits);
		logic [63:0] v;
		v = '0;
		for (int k = 0; k < nBits; k++)
			v = {v[62:0], lfsrStep()};
		return v;
	endfunction

	task automatic checkEq(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Issues one instruction and waits for its retire record
	task automatic execOne(input string name, input instrWordT w, input logic [31:0] ipIn,
		input logic [63:0] a, input logic [63:0] b, input logic [63:0] c,
		input logic take = 1'b0, input logic pred = 1'b0,
		input logic [15:0] cause = 16'h0000, input logic stale = 1'b0);
		int waited;
		@(posedge clk);
		issueValid <= 1'b1;
		instr <= w;
		ip <= ipIn;
		opA <= a;
		opB <= b;
		opC <= c;
		takeBranch <= take;
		predictTaken <= pred;
		causeIn <= cause;
		streamTag <= stale ? 6'(curStream - 1) : 6'(curStream);
		@(posedge clk);
		issueValid <= 1'b0;
		waited = 0;
		@(negedge clk);
		while (!retireValid && waited < RetireTimeout) begin
			@(negedge clk);
			waited++;
		end
		if (!retireValid) begin
			errors++;
			$display("Timeout: %s did not retire within %0d cycles", name, RetireTimeout);
		end
		else begin
			checkEq({name, " idx"}, 64'(expIdx), 64'(retireIdx));
			expIdx = (expIdx == RobEntries - 1) ? 0 : expIdx + 1;
		end
	endtask

	task automatic checkRetire(input string name, input logic [63:0] expResult,
		input logic [15:0] expCause, input logic expSquash, input logic expRedirect);
		checkEq({name, " result"}, expResult, retireResult);
		checkEq({name, " cause"}, 64'(expCause), 64'(retireCause));
		checkEq({name, " squash"}, 64'(expSquash), 64'(retireSquashed));
		checkEq({name, " redirect"}, 64'(expRedirect), 64'(redirectValid));
		checkEq({name, " flush"}, 64'(expRedirect), 64'(flush));
	endtask

	`include "execTests.svh"

	// ====================
	// Test sequence
	// ====================
	initial begin
		rst = 1'b1;
		issueValid = 1'b0;
		instr = '0;
		ip = '0;
		opA = '0;
		opB = '0;
		opC = '0;
		streamTag = '0;
		causeIn = '0;
		takeBranch = 1'b0;
		predictTaken = 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		testReset();
		testAluOps();
		testIndexWrap();
		testByteIndex();
		testBoundsCheck();
		testBranches();
		testSquashFault();
		repeat (2) @(posedge clk);
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- tb.f
+incdir+tb
hw/execPkg.sv
hw/intAlu.sv
hw/branchCheck.sv
hw/execCommit.sv
hw/execStage.sv
tb/execStageTb.sv

//--- Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= execStageTb
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) -Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)

# The simulation counts as passed only when the pass line shows up in its output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
